//--- design/isa_pkg.sv
package isa_pkg;

  // primary opcodes sit in bits 30:25 of the instruction word.
  localparam logic [5:0] op_alu  = 6'b100000;
  localparam logic [5:0] op_addi = 6'b101000;
  localparam logic [5:0] op_ori  = 6'b101100;
  localparam logic [5:0] op_xori = 6'b101011;
  localparam logic [5:0] op_movi = 6'b100010;

  // sub-opcodes of the register-register group sit in bits 4:0.
  localparam logic [4:0] sub_add   = 5'b00000;
  localparam logic [4:0] sub_sub   = 5'b00001;
  localparam logic [4:0] sub_and   = 5'b00010;
  localparam logic [4:0] sub_xor   = 5'b00011;
  localparam logic [4:0] sub_or    = 5'b00100;
  localparam logic [4:0] sub_slli  = 5'b01000;
  localparam logic [4:0] sub_srli  = 5'b01001;
  localparam logic [4:0] sub_rotri = 5'b01011;

  // bits 14:10 carry the second source register or the shift amount.
  typedef union packed {
    logic [4:0] rb;
    logic [4:0] imm5;
  } src_b_t;

  typedef struct packed {
    logic       reserved_31;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    src_b_t     src_b;
    logic [4:0] reserved_9_5;
    logic [4:0] sub_opcode;
  } instr_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_ror,
    alu_pass_b
  } alu_op_e;

endpackage

//--- design/core_pkg.sv
package core_pkg;

  import isa_pkg::*;

  // one instruction walks through these four steps in order.
  typedef enum logic [1:0] {
    state_stop    = 2'b00,
    state_fetch   = 2'b01,
    state_execute = 2'b10,
    state_write   = 2'b11
  } state_e;

  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_kind_e;

  typedef enum logic {
    wb_alu_result = 1'b0,
    wb_operand_b  = 1'b1
  } wb_source_e;

  typedef struct packed {
    logic       fetch_enable;
    logic       execute_enable;
    logic       writeback_enable;
    imm_kind_e  imm_kind;
    logic       use_imm;
    wb_source_e wb_source;
    alu_op_e    alu_op;
  } ctrl_t;

endpackage

//--- design/ir_controller.sv
module ir_controller
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [data_width-1:0] pc,
  input  instr_t                ir,
  output ctrl_t                 ctrl,
  output instr_t                instr
);

  state_e state;
  state_e next_state;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= state_stop;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      state_stop:    next_state = state_fetch;
      state_fetch:   next_state = state_execute;
      state_execute: next_state = state_write;
      default:       next_state = state_stop;
    endcase
  end

  // the word is captured at the edge that closes the fetch cycle.
  // a pc of zero turns the slot into an all-zero word, which adds r0 to r0.
  always_ff @(posedge clock) begin
    if (state == state_fetch) begin
      instr <= (pc == '0) ? '0 : ir;
    end
  end

  always_comb begin
    ctrl.fetch_enable     = (state == state_fetch);
    ctrl.execute_enable   = (state == state_execute);
    ctrl.writeback_enable = (state == state_write);
    ctrl.imm_kind         = imm5_ze;
    ctrl.use_imm          = 1'b0;
    ctrl.wb_source        = wb_alu_result;
    ctrl.alu_op           = alu_add;

    case (instr.opcode)
      op_alu: begin
        case (instr.sub_opcode)
          sub_sub: ctrl.alu_op = alu_sub;
          sub_and: ctrl.alu_op = alu_and;
          sub_or:  ctrl.alu_op = alu_or;
          sub_xor: ctrl.alu_op = alu_xor;
          sub_slli: begin
            ctrl.alu_op  = alu_sll;
            ctrl.use_imm = 1'b1;
          end
          sub_srli: begin
            ctrl.alu_op  = alu_srl;
            ctrl.use_imm = 1'b1;
          end
          sub_rotri: begin
            ctrl.alu_op  = alu_ror;
            ctrl.use_imm = 1'b1;
          end
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_addi: begin
        ctrl.alu_op   = alu_add;
        ctrl.imm_kind = imm15_se;
        ctrl.use_imm  = 1'b1;
      end
      op_ori: begin
        ctrl.alu_op   = alu_or;
        ctrl.imm_kind = imm15_ze;
        ctrl.use_imm  = 1'b1;
      end
      op_xori: begin
        ctrl.alu_op   = alu_xor;
        ctrl.imm_kind = imm15_ze;
        ctrl.use_imm  = 1'b1;
      end
      op_movi: begin
        // the immediate bypasses the alu and goes straight to write-back.
        ctrl.alu_op    = alu_pass_b;
        ctrl.imm_kind  = imm20_se;
        ctrl.use_imm   = 1'b1;
        ctrl.wb_source = wb_operand_b;
      end
      default: ctrl.alu_op = alu_add;
    endcase
  end

endmodule

//--- design/register_file.sv
module register_file #(
  parameter int data_width     = 32,
  parameter int reg_addr_width = 5
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] read_address_a,
  input  logic [reg_addr_width-1:0] read_address_b,
  output logic [data_width-1:0]     read_data_a,
  output logic [data_width-1:0]     read_data_b,
  input  logic                      write_enable,
  input  logic [reg_addr_width-1:0] write_address,
  input  logic [data_width-1:0]     write_data
);

  localparam int reg_count = 2 ** reg_addr_width;

  logic [data_width-1:0] regs [reg_count];

  // r0 is plain storage here, it is not tied to zero.
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_address] <= write_data;
    end
  end

  // reads are combinational so operands are ready during execute.
  assign read_data_a = regs[read_address_a];
  assign read_data_b = regs[read_address_b];

endmodule

//--- design/operand_select.sv
module operand_select
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic [data_width-1:0] register_b,
  input  instr_t                instr,
  input  ctrl_t                 ctrl,
  output logic [data_width-1:0] operand_b
);

  logic [data_width-1:0] immediate;

  always_comb begin
    case (ctrl.imm_kind)
      imm5_ze:  immediate = {{(data_width - 5){1'b0}}, instr.src_b.imm5};
      imm15_se: immediate = {{(data_width - 15){instr[14]}}, instr[14:0]};
      imm15_ze: immediate = {{(data_width - 15){1'b0}}, instr[14:0]};
      // covers imm20_se.
      default:  immediate = {{(data_width - 20){instr[19]}}, instr[19:0]};
    endcase
  end

  assign operand_b = ctrl.use_imm ? immediate : register_b;

endmodule

//--- design/alu.sv
module alu
  import isa_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  execute_enable,
  input  alu_op_e               alu_op,
  input  logic [data_width-1:0] operand_a,
  input  logic [data_width-1:0] operand_b,
  output logic [data_width-1:0] result
);

  logic [4:0]              shift_amount;
  logic [2*data_width-1:0] rotate_full;
  logic [data_width-1:0]   next_result;

  assign shift_amount = operand_b[4:0];

  // shifting the doubled word right leaves the rotated value in the low half.
  assign rotate_full = {operand_a, operand_a} >> shift_amount;

  always_comb begin
    case (alu_op)
      alu_add:    next_result = operand_a + operand_b;
      alu_sub:    next_result = operand_a - operand_b;
      alu_and:    next_result = operand_a & operand_b;
      alu_or:     next_result = operand_a | operand_b;
      alu_xor:    next_result = operand_a ^ operand_b;
      alu_sll:    next_result = operand_a << shift_amount;
      alu_srl:    next_result = operand_a >> shift_amount;
      alu_ror:    next_result = rotate_full[data_width-1:0];
      alu_pass_b: next_result = operand_b;
      default:    next_result = operand_a + operand_b;
    endcase
  end

  // the result is held from the end of execute through the write step.
  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (execute_enable) begin
      result <= next_result;
    end
  end

endmodule

//--- design/cpu_core.sv
module cpu_core
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int data_width     = 32,
  parameter int reg_addr_width = 5
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [data_width-1:0]     pc,
  input  instr_t                    ir,
  output logic                      fetch_enable,
  output logic                      write_enable,
  output logic [reg_addr_width-1:0] write_address,
  output logic [data_width-1:0]     write_data
);

  ctrl_t                 ctrl;
  instr_t                instr;
  logic [data_width-1:0] register_a;
  logic [data_width-1:0] register_b;
  logic [data_width-1:0] operand_b;
  logic [data_width-1:0] alu_result;

  ir_controller #(
    .data_width (data_width)
  ) u_ir_controller (
    .clock (clock),
    .reset (reset),
    .pc    (pc),
    .ir    (ir),
    .ctrl  (ctrl),
    .instr (instr)
  );

  register_file #(
    .data_width     (data_width),
    .reg_addr_width (reg_addr_width)
  ) u_register_file (
    .clock          (clock),
    .reset          (reset),
    .read_address_a (reg_addr_width'(instr.ra)),
    .read_address_b (reg_addr_width'(instr.src_b.rb)),
    .read_data_a    (register_a),
    .read_data_b    (register_b),
    .write_enable   (ctrl.writeback_enable),
    .write_address  (write_address),
    .write_data     (write_data)
  );

  operand_select #(
    .data_width (data_width)
  ) u_operand_select (
    .register_b (register_b),
    .instr      (instr),
    .ctrl       (ctrl),
    .operand_b  (operand_b)
  );

  alu #(
    .data_width (data_width)
  ) u_alu (
    .clock          (clock),
    .reset          (reset),
    .execute_enable (ctrl.execute_enable),
    .alu_op         (ctrl.alu_op),
    .operand_a      (register_a),
    .operand_b      (operand_b),
    .result         (alu_result)
  );

  assign fetch_enable  = ctrl.fetch_enable;
  assign write_enable  = ctrl.writeback_enable;
  assign write_address = reg_addr_width'(instr.rt);

  // movi writes its immediate directly, everything else writes the alu result.
  assign write_data = (ctrl.wb_source == wb_operand_b) ? operand_b : alu_result;

endmodule

//--- verification/cpu_core_checker.sv
module cpu_core_checker
  import core_pkg::*;
(
  input logic  clock,
  input logic  reset,
  input ctrl_t ctrl
);

  logic [2:0] stage_enables;

  assign stage_enables = {ctrl.fetch_enable, ctrl.execute_enable, ctrl.writeback_enable};

  one_stage_at_a_time: assert property (
    @(posedge clock) disable iff (reset) $onehot0(stage_enables)
  ) else $error("more than one stage enable is high in the same cycle");

  // the stages advance in lock step, one cycle each.
  execute_after_fetch: assert property (
    @(posedge clock) disable iff (reset) ctrl.fetch_enable |=> ctrl.execute_enable
  ) else $error("execute_enable did not follow fetch_enable");

  write_after_execute: assert property (
    @(posedge clock) disable iff (reset) ctrl.execute_enable |=> ctrl.writeback_enable
  ) else $error("writeback_enable did not follow execute_enable");

endmodule

bind ir_controller cpu_core_checker u_cpu_core_checker (
  .clock (clock),
  .reset (reset),
  .ctrl  (ctrl)
);

//--- verification/cpu_core_tb.sv
module cpu_core_tb
  import isa_pkg::*;
();

  localparam int    clock_period = 40;
  localparam int    drive_delay  = 2;
  localparam int    reset_cycles = 4;
  localparam int    wait_limit   = 16;
  localparam string data_path    = "verification/cpu_core_testdata.txt";

  logic        clock;
  logic        reset;
  logic [31:0] pc;
  instr_t      ir;
  logic        fetch_enable;
  logic        write_enable;
  logic [4:0]  write_address;
  logic [31:0] write_data;

  int cycle;
  int last_fetch_cycle;
  int vectors_checked;

  cpu_core #(
    .data_width     (32),
    .reg_addr_width (5)
  ) u_cpu_core (
    .clock         (clock),
    .reset         (reset),
    .pc            (pc),
    .ir            (ir),
    .fetch_enable  (fetch_enable),
    .write_enable  (write_enable),
    .write_address (write_address),
    .write_data    (write_data)
  );

  always #(clock_period / 2) clock = ~clock;

  // inputs change and outputs are sampled a short time after each rising edge.
  task automatic next_cycle();
    @(posedge clock);
    #drive_delay;
    cycle++;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic wait_for_fetch(output int waited);
    waited = 0;
    while (fetch_enable !== 1'b1) begin
      if (waited == wait_limit) begin
        $display("fetch_enable never rose");
        $display("Test failed");
        $fatal(1, "timeout while waiting for the fetch step");
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  task automatic run_vector(input int index, input logic [31:0] vec_pc,
                            input logic [31:0] vec_ir, input logic [31:0] exp_address,
                            input logic [31:0] exp_data);
    string name;
    int    waited;
    name = $sformatf("vector %0d", index);
    wait_for_fetch(waited);
    if (vectors_checked == 0) begin
      check_value({name, " first fetch delay"}, 32'd1, waited);
    end else begin
      check_value({name, " fetch period"}, 32'd4, cycle - last_fetch_cycle);
    end
    check_value({name, " write_enable in fetch"}, 32'd0, {31'd0, write_enable});
    last_fetch_cycle = cycle;
    pc = vec_pc;
    ir = vec_ir;
    next_cycle();
    check_value({name, " write_enable in execute"}, 32'd0, {31'd0, write_enable});
    next_cycle();
    check_value({name, " write_enable in write"}, 32'd1, {31'd0, write_enable});
    check_value({name, " write_address"}, exp_address, 32'(write_address));
    check_value({name, " write_data"}, exp_data, write_data);
    next_cycle();
    check_value({name, " write_enable in stop"}, 32'd0, {31'd0, write_enable});
    vectors_checked++;
  endtask

  initial begin
    int          fd;
    int          fields;
    int          line_number;
    string       line;
    logic [31:0] vec_pc;
    logic [31:0] vec_ir;
    logic [31:0] exp_address;
    logic [31:0] exp_data;
    clock            = 1'b0;
    reset            = 1'b1;
    pc               = '0;
    ir               = '0;
    cycle            = 0;
    last_fetch_cycle = 0;
    vectors_checked  = 0;
    line_number      = 0;
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      $display("could not open the test data file %s", data_path);
      $display("Test failed");
      $fatal(1, "missing test data");
    end
    repeat (reset_cycles) next_cycle();
    reset = 1'b0;
    check_value("fetch_enable after reset", 32'd0, {31'd0, fetch_enable});
    check_value("write_enable after reset", 32'd0, {31'd0, write_enable});
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        line_number++;
        if (line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h", vec_pc, vec_ir, exp_address, exp_data);
          if (fields == 4) begin
            run_vector(line_number, vec_pc, vec_ir, exp_address, exp_data);
          end
        end
      end
    end
    $fclose(fd);
    if (vectors_checked > 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("no instruction lines were found in the test data file");
      $display("Test failed");
      $fatal(1, "empty test data");
    end
  end

endmodule

//--- verification/cpu_core_testdata.txt
# columns, all hex: pc, instruction word, expected write address, expected write data
# registers start at zero after reset and each line runs one instruction in order
00000100 44112345 01 00012345
00000104 442fff0f 02 ffffff0f
00000108 44380001 03 fff80001
0000010c 40408800 04 00012254
00000110 40508c01 05 00092344
00000114 40608802 06 00012305
00000118 40708c04 07 fff92345
0000011c 40810c03 08 0007ff0e
00000120 40909008 09 00123450
00000124 40a1a009 0a 00fff800
00000128 40b1900b 0b 1fff8000
0000012c 40c1300b 0c f0ffffff
00000130 50d0fff0 0d 00012335
00000134 58e0c100 0e 00016345
00000138 56f1ffff 0f fff87ffe
0000013c 40022400 00 001356a4
00000000 44112345 00 0026ad48
00000140 41001400 10 002fd08c
00000144 41110401 11 fffedbca

//--- cpu_core.f
design/isa_pkg.sv
design/core_pkg.sv
design/ir_controller.sv
design/register_file.sv
design/operand_select.sv
design/alu.sv
design/cpu_core.sv
verification/cpu_core_checker.sv
verification/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim \
  && ./obj_dir/cpu_core_sim > sim.log 2>&1
grep -q "Test completed successfully" sim.log \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed, see sim.log"; exit 1; }
